//--- Bender.yml
package:
  name: pim_dma

sources:
  - include_dirs:
      - source
    files:
      - source/pim_cmd_pkg.sv
      - source/pim_bus_pkg.sv
      - source/dma_cmd_fsm.sv
      - source/dma_word_counter.sv
      - source/dma_operand_regs.sv
      - source/dma_bus_mux.sv
      - source/pim_dma_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/pim_dma_chk.sv
      - sim/tb_pim_dma.sv

//--- sim/pim_dma_cases.txt
// columns: opcode rs1 rs2 exp_addr exp_value, all hex
// exp_addr below 00001000 is an SRAM byte address, otherwise a PIM address
1 00000010 0000abcd 40000010 0000abcd // ERASE
2 00000020 13572468 40000020 13572468 // PROGRAM
4 00000000 000000c8 42000000 000000c8 // ZP
3 00000040 00000100 00000100 e5a5a5e5 // READ
5 00000080 00000200 40000080 5a5a0200 // PARALLEL
0 00000050 00000011 00000000 00000000 // unsupported
6 00000060 00000022 00000000 00000000 // RBR, dropped
7 00000070 00000033 00000000 00000000 // LOAD, dropped
2 00000030 deadbeef 40000030 deadbeef // PROGRAM
3 00000044 00000104 00000104 e5a5a5e1 // READ
5 00000100 00000400 40000100 5a5a0400 // PARALLEL
1 00000abc 00c0ffee 40000abc 00c0ffee // ERASE
4 00000000 00000077 42000000 00000077 // ZP

//--- sim/pim_dma_chk.sv
`timescale 1ns/1ps
`default_nettype none

module pim_dma_chk
    import pim_bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     gnt_i,
    input  logic     busy_i,
    input  bus_req_t sram_bus_i,
    input  bus_req_t pim_bus_i
);

    int   violations = 0;
    logic sram_strobe;
    logic pim_strobe;

    assign sram_strobe = sram_bus_i.read || sram_bus_i.write;
    assign pim_strobe  = pim_bus_i.read || pim_bus_i.write;

    // back-pressure holds every strobe low
    a_gnt_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !gnt_i |-> !(sram_strobe || pim_strobe))
        else begin
            $error("bus strobe without grant");
            violations++;
        end

    a_sram_rw: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(sram_bus_i.read && sram_bus_i.write))
        else begin
            $error("sram read and write together");
            violations++;
        end

    a_pim_rw: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pim_bus_i.read && pim_bus_i.write))
        else begin
            $error("pim read and write together");
            violations++;
        end

    // idle engine stays off both buses
    a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !busy_i |-> !(sram_strobe || pim_strobe))
        else begin
            $error("bus strobe while not busy");
            violations++;
        end

endmodule

bind pim_dma_top pim_dma_chk u_chk (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .gnt_i      (bus_gnt_i),
    .busy_i     (dma_busy_o),
    .sram_bus_i (sram_bus_o),
    .pim_bus_i  (pim_bus_o)
);

`default_nettype wire

//--- sim/tb_pim_dma.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_dma_macros.svh"

module tb_pim_dma
    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int MAX_CASES    = 32;
    localparam int WAIT_LIMIT   = 2000;
    localparam int STALL_CYCLES = 20;

    logic        clk;
    logic        rst_n;
    logic        dma_en;
    logic [2:0]  funct3;
    addr_t       rs1;
    word_t       rs2;
    logic        bus_gnt;
    logic        rand_grant;
    word_t       sram_rdata;
    word_t       pim_rdata;
    logic        bus_req;
    logic        dma_busy;
    bus_req_t    sram_bus;
    bus_req_t    pim_bus;

    // SRAM of 1024 words from byte address 0
    word_t       sram_mem [0:1023];
    // PIM kept as a write log
    addr_t       pim_addr_log [$];
    word_t       pim_data_log [$];
    word_t       pim_status;
    int          pim_wr_cnt;
    int          sram_wr_cnt;
    logic [31:0] case_mem [0:5*MAX_CASES-1];
    int          err_value;
    int          err_other;
    int unsigned seed;

    pim_dma_top uut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .dma_en_i     (dma_en),
        .funct3_i     (funct3),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .bus_gnt_i    (bus_gnt),
        .sram_rdata_i (sram_rdata),
        .pim_rdata_i  (pim_rdata),
        .bus_req_o    (bus_req),
        .sram_bus_o   (sram_bus),
        .pim_bus_o    (pim_bus),
        .dma_busy_o   (dma_busy)
    );

    function automatic word_t sram_fill(addr_t a);
        return a ^ 32'h5A5A_0000;
    endfunction

    function automatic word_t pim_fill(addr_t a);
        return a ^ 32'hA5A5_A5A5;
    endfunction

    // latest write wins and untouched locations read the fill pattern
    function automatic word_t pim_lookup(addr_t a);
        for (int i = pim_addr_log.size() - 1; i >= 0; i--) begin
            if (pim_addr_log[i] == a) begin
                return pim_data_log[i];
            end
        end
        return pim_fill(a);
    endfunction

    always @(posedge clk) begin
        if (sram_bus.write || sram_bus.read) begin
            compare_word("sram_bus_o.be", word_t'(sram_bus.be), 32'h0000_000F);
        end
        if (sram_bus.write) begin
            sram_mem[sram_bus.addr[11:2]] <= sram_bus.wdata;
            sram_wr_cnt <= sram_wr_cnt + 1;
        end
        if (sram_bus.read) begin
            sram_rdata <= sram_mem[sram_bus.addr[11:2]];
        end
    end

    always @(posedge clk) begin
        if (pim_bus.write || pim_bus.read) begin
            compare_word("pim_bus_o.be", word_t'(pim_bus.be), 32'h0000_000F);
        end
        if (pim_bus.write) begin
            pim_addr_log.push_back(pim_bus.addr);
            pim_data_log.push_back(pim_bus.wdata);
            pim_wr_cnt <= pim_wr_cnt + 1;
        end
        if (pim_bus.read) begin
            pim_rdata <= (pim_bus.addr == `PIM_STATUS_ADDR) ? pim_status
                                                            : pim_lookup(pim_bus.addr);
        end
    end

    // grant is full or a 3-in-4 random pattern
    always @(posedge clk) begin
        #DRIVE_DELAY;
        bus_gnt = rand_grant ? ($urandom_range(3) != 0) : 1'b1;
    end

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            err_value++;
        end
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
            err_value++;
        end
    endtask

    task automatic close_run();
        int total;
        total = err_value + err_other + uut.u_chk.violations;
        $display("errors: value %0d, other %0d, protocol %0d",
                 err_value, err_other, uut.u_chk.violations);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (dma_busy && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (dma_busy) begin
            $display("timeout: dma_busy_o still high after %0d cycles", WAIT_LIMIT);
            err_other++;
            close_run();
        end
    endtask

    task automatic run_case(input int idx, input bit stall);
        logic [2:0] op;
        addr_t      exp_addr;
        word_t      exp_val;
        addr_t      row;
        op       = case_mem[5*idx][2:0];
        exp_addr = case_mem[5*idx+3];
        exp_val  = case_mem[5*idx+4];
        row      = `PIM_BASE_ADDR + case_mem[5*idx+1];
        // valid alone keeps READ waiting for data-ready
        pim_status = !stall ? 32'h3 : ((op == READ) ? 32'h1 : 32'h0);
        @(posedge clk);
        #DRIVE_DELAY;
        pim_wr_cnt  = 0;
        sram_wr_cnt = 0;
        dma_en      = 1'b1;
        funct3      = op;
        rs1         = case_mem[5*idx+1];
        rs2         = case_mem[5*idx+2];
        @(posedge clk);
        #DRIVE_DELAY;
        dma_en = 1'b0;
        if (op == 3'd0 || op > 3'd5) begin
            repeat (5) begin
                @(posedge clk);
                #1;
                expect_flag("dma_busy_o", dma_busy, 1'b0);
                expect_flag("bus_req_o", bus_req, 1'b0);
            end
            compare_word("pim write count", pim_wr_cnt, 0);
        end else begin
            if (stall) begin
                repeat (STALL_CYCLES) begin
                    @(posedge clk);
                    #1;
                    expect_flag("dma_busy_o", dma_busy, 1'b1);
                    expect_flag("bus_req_o", bus_req, 1'b1);
                    compare_word("pim write count", pim_wr_cnt, 0);
                    compare_word("sram write count", sram_wr_cnt, 0);
                end
                pim_status = 32'h3;
            end
            wait_idle();
            compare_word("pim mode register", pim_lookup(`PIM_MODE_ADDR), word_t'(op));
            if (exp_addr < 32'h1000) begin
                compare_word($sformatf("sram[%h]", exp_addr), sram_mem[exp_addr[11:2]], exp_val);
            end else begin
                compare_word($sformatf("pim[%h]", exp_addr), pim_lookup(exp_addr), exp_val);
            end
            if (op == PARALLEL) begin
                for (int k = 0; k < `PARALLEL_WORDS; k++) begin
                    compare_word($sformatf("pim slot %0d", k),
                                 pim_lookup(row | (addr_t'(k) << `SLOT_SHIFT)),
                                 sram_fill(rs2 + 32'd4 * k));
                end
            end
            compare_word("pim write count", pim_wr_cnt,
                         (op == PARALLEL) ? 17 : ((op == READ) ? 1 : 2));
            compare_word("sram write count", sram_wr_cnt, (op == READ) ? 1 : 0);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        int n_cases;
        seed        = 41;
        void'($urandom(seed));
        rst_n       = 1'b0;
        dma_en      = 1'b0;
        funct3      = 3'd0;
        rs1         = '0;
        rs2         = '0;
        bus_gnt     = 1'b0;
        rand_grant  = 1'b0;
        sram_rdata  = '0;
        pim_rdata   = '0;
        pim_status  = 32'h3;
        pim_wr_cnt  = 0;
        sram_wr_cnt = 0;
        err_value   = 0;
        err_other   = 0;
        for (int i = 0; i < 1024; i++) begin
            sram_mem[i] = sram_fill(addr_t'(i * 4));
        end
        for (int i = 0; i < 5 * MAX_CASES; i++) begin
            case_mem[i] = '1;
        end
        $readmemh("sim/pim_dma_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && case_mem[5*n_cases] != 32'hFFFF_FFFF) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("no cases found in sim/pim_dma_cases.txt");
            err_other++;
        end
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        // a full-grant pass with held-off status before the random-grant pass
        for (int i = 0; i < n_cases; i++) begin
            run_case(i, 1'b1);
        end
        rand_grant = 1'b1;
        for (int i = 0; i < n_cases; i++) begin
            run_case(i, 1'b0);
        end
        close_run();
    end

endmodule

`default_nettype wire

//--- source/dma_bus_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_dma_macros.svh"

module dma_bus_mux
    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;
(
    input  dma_state_e phase_i,
    input  logic       bus_gnt_i,
    input  dma_cmd_t   cmd_i,
    input  addr_t      sram_addr_i,
    input  word_cnt_t  index_i,
    input  logic       last_i,
    input  word_t      sram_rdata_i,
    input  word_t      pim_rdata_i,
    output bus_req_t   sram_bus_o,
    output bus_req_t   pim_bus_o
);

    addr_t row_addr;
    addr_t slot_addr;

    assign row_addr  = `PIM_BASE_ADDR + cmd_i.rc_addr;
    // slot k of a parallel transfer
    assign slot_addr = row_addr | (addr_t'(index_i) << `SLOT_SHIFT);

    always_comb begin
        sram_bus_o = '0;
        pim_bus_o  = '0;
        case (phase_i)
            SETUP: begin
                pim_bus_o.addr = `PIM_STATUS_ADDR;
                pim_bus_o.read = 1'b1;
                pim_bus_o.be   = `BUS_BE_ALL;
            end
            MODE: begin
                pim_bus_o.addr  = `PIM_MODE_ADDR;
                pim_bus_o.write = 1'b1;
                pim_bus_o.be    = `BUS_BE_ALL;
                pim_bus_o.wdata = word_t'(cmd_i.opcode);
            end
            R_EXE: begin
                if (cmd_i.opcode == READ) begin
                    pim_bus_o.addr = row_addr;
                    pim_bus_o.read = 1'b1;
                    pim_bus_o.be   = `BUS_BE_ALL;
                end else begin
                    sram_bus_o.addr = sram_addr_i;
                    sram_bus_o.read = 1'b1;
                    sram_bus_o.be   = `BUS_BE_ALL;
                end
            end
            RW_EXE: begin
                pim_bus_o.addr  = slot_addr;
                pim_bus_o.write = 1'b1;
                pim_bus_o.be    = `BUS_BE_ALL;
                pim_bus_o.wdata = sram_rdata_i;
                // prefetch the next word unless this write ends the transfer
                if (!last_i) begin
                    sram_bus_o.addr = sram_addr_i;
                    sram_bus_o.read = 1'b1;
                    sram_bus_o.be   = `BUS_BE_ALL;
                end
            end
            W_EXE: begin
                if (cmd_i.opcode == READ) begin
                    sram_bus_o.addr  = sram_addr_i;
                    sram_bus_o.write = 1'b1;
                    sram_bus_o.be    = `BUS_BE_ALL;
                    sram_bus_o.wdata = pim_rdata_i;
                end else begin
                    pim_bus_o.addr  = (cmd_i.opcode == ZP) ? `PIM_ZP_ADDR : row_addr;
                    pim_bus_o.write = 1'b1;
                    pim_bus_o.be    = `BUS_BE_ALL;
                    pim_bus_o.wdata = cmd_i.operand;
                end
            end
            default: begin
                sram_bus_o = '0;
                pim_bus_o  = '0;
            end
        endcase

        // back-pressure, no strobe leaves without grant
        if (!bus_gnt_i) begin
            sram_bus_o.read  = 1'b0;
            sram_bus_o.write = 1'b0;
            pim_bus_o.read   = 1'b0;
            pim_bus_o.write  = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/dma_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_dma_macros.svh"

module dma_cmd_fsm
    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       dma_en_i,
    input  opcode_e    funct3_i,
    input  logic       bus_gnt_i,
    input  word_t      pim_status_i,
    input  logic       last_i,
    output dma_state_e phase_o,
    output logic       cmd_load_o,
    output logic       cnt_load_o,
    output logic       cnt_step_o,
    output logic       addr_step_o,
    output logic       busy_o,
    output logic       bus_req_o
);

    dma_state_e state_q;
    dma_state_e state_d;
    // opcode class of the running command
    logic       rd_cmd_q;
    logic       par_cmd_q;
    // a granted status read has returned data in this SETUP
    logic       status_seen_q;
    logic       supported;
    logic       status_ok;

    always_comb begin
        case (funct3_i)
            ERASE, PROGRAM, READ, ZP, PARALLEL: supported = 1'b1;
            default: supported = 1'b0;
        endcase
    end

    assign cmd_load_o = (state_q == IDLE) && dma_en_i && supported;

    // READ also waits for data-ready
    assign status_ok = pim_status_i[`STATUS_VALID_BIT] &&
                       (!rd_cmd_q || pim_status_i[`STATUS_DATA_BIT]);

    always_comb begin
        state_d     = state_q;
        cnt_load_o  = 1'b0;
        cnt_step_o  = 1'b0;
        addr_step_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (cmd_load_o) begin
                    state_d = SETUP;
                end
            end
            SETUP: begin
                if (bus_gnt_i && status_seen_q && status_ok) begin
                    state_d = MODE;
                end
            end
            MODE: begin
                if (bus_gnt_i) begin
                    cnt_load_o = 1'b1;
                    state_d    = (rd_cmd_q || par_cmd_q) ? R_EXE : W_EXE;
                end
            end
            R_EXE: begin
                if (bus_gnt_i) begin
                    // parallel fetched its first SRAM word
                    addr_step_o = par_cmd_q;
                    state_d     = par_cmd_q ? RW_EXE : W_EXE;
                end
            end
            RW_EXE: begin
                if (bus_gnt_i) begin
                    cnt_step_o  = 1'b1;
                    addr_step_o = !last_i;
                    if (last_i) begin
                        state_d = IDLE;
                    end
                end
            end
            W_EXE: begin
                if (bus_gnt_i) begin
                    cnt_step_o = 1'b1;
                    if (last_i) begin
                        state_d = IDLE;
                    end
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= IDLE;
            rd_cmd_q      <= 1'b0;
            par_cmd_q     <= 1'b0;
            status_seen_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            status_seen_q <= (state_q == SETUP) && (status_seen_q || bus_gnt_i);
            if (cmd_load_o) begin
                rd_cmd_q  <= (funct3_i == READ);
                par_cmd_q <= (funct3_i == PARALLEL);
            end
        end
    end

    assign phase_o   = state_q;
    assign busy_o    = (state_q != IDLE);
    assign bus_req_o = (state_q != IDLE);

endmodule

`default_nettype wire

//--- source/dma_operand_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_operand_regs
    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     load_i,
    input  opcode_e  funct3_i,
    input  addr_t    rs1_i,
    input  word_t    rs2_i,
    input  logic     addr_step_i,
    output dma_cmd_t cmd_o,
    output addr_t    sram_addr_o
);

    dma_cmd_t cmd_q;
    addr_t    sram_addr_q;

    // command stays fixed for the whole transfer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmd_q <= '0;
        end else if (load_i) begin
            cmd_q.opcode  <= funct3_i;
            cmd_q.rc_addr <= rs1_i;
            cmd_q.operand <= rs2_i;
        end
    end

    // SRAM word pointer, rs2 is a byte address
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sram_addr_q <= '0;
        end else if (load_i) begin
            sram_addr_q <= rs2_i;
        end else if (addr_step_i) begin
            sram_addr_q <= sram_addr_q + 32'd4;
        end
    end

    assign cmd_o       = cmd_q;
    assign sram_addr_o = sram_addr_q;

endmodule

`default_nettype wire

//--- source/dma_word_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_dma_macros.svh"

module dma_word_counter
    import pim_cmd_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      load_i,
    input  logic      step_i,
    input  opcode_e   opcode_i,
    output word_cnt_t index_o,
    output logic      last_o
);

    word_cnt_t index_q;
    // number of writes in this command
    word_cnt_t limit_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            index_q <= '0;
            limit_q <= '0;
        end else if (load_i) begin
            index_q <= '0;
            limit_q <= (opcode_i == PARALLEL) ? word_cnt_t'(`PARALLEL_WORDS) : word_cnt_t'(1);
        end else if (step_i) begin
            index_q <= index_q + 1'b1;
        end
    end

    assign index_o = index_q;
    // the write now on the bus is the final one
    assign last_o  = (index_q == limit_q - 1'b1);

endmodule

`default_nettype wire

//--- source/pim_bus_pkg.sv
`default_nettype none

package pim_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // one request on an SRAM or PIM port
    typedef struct packed {
        addr_t      addr;
        logic       write;
        logic       read;
        logic [3:0] be;
        word_t      wdata;
    } bus_req_t;

endpackage

`default_nettype wire

//--- source/pim_cmd_pkg.sv
`default_nettype none

package pim_cmd_pkg;

    // supported command codes, funct3 values 0, 6 and 7 are not accepted
    typedef enum logic [2:0] {
        ERASE    = 3'd1,
        PROGRAM  = 3'd2,
        READ     = 3'd3,
        ZP       = 3'd4,
        PARALLEL = 3'd5
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        MODE,
        R_EXE,
        RW_EXE,
        W_EXE
    } dma_state_e;

    // word index and count of one transfer
    typedef logic [4:0] word_cnt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [31:0] rc_addr;
        logic [31:0] operand;
    } dma_cmd_t;

endpackage

`default_nettype wire

//--- source/pim_dma_macros.svh
`ifndef PIM_DMA_MACROS_SVH
`define PIM_DMA_MACROS_SVH

// PIM register map
`define PIM_BASE_ADDR    32'h4000_0000
`define PIM_MODE_ADDR    32'h4100_0000
`define PIM_ZP_ADDR      32'h4200_0000
`define PIM_STATUS_ADDR  32'h4300_0000

// all four byte lanes on every access
`define BUS_BE_ALL       4'b1111

// PARALLEL moves this many words
`define PARALLEL_WORDS   16

// slots of a parallel transfer sit 4 KiB apart
`define SLOT_SHIFT       12

// bits in the PIM status word
`define STATUS_VALID_BIT 0
`define STATUS_DATA_BIT  1

`endif

//--- source/pim_dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module pim_dma_top
    import pim_cmd_pkg::*;
    import pim_bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       dma_en_i,
    input  logic [2:0] funct3_i,
    input  addr_t      rs1_i,
    input  word_t      rs2_i,
    input  logic       bus_gnt_i,
    input  word_t      sram_rdata_i,
    input  word_t      pim_rdata_i,
    output logic       bus_req_o,
    output bus_req_t   sram_bus_o,
    output bus_req_t   pim_bus_o,
    output logic       dma_busy_o
);

    dma_state_e phase;
    dma_cmd_t   cmd;
    addr_t      sram_addr;
    word_cnt_t  index;
    logic       last;
    logic       cmd_load;
    logic       cnt_load;
    logic       cnt_step;
    logic       addr_step;

    dma_cmd_fsm u_fsm (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .dma_en_i     (dma_en_i),
        .funct3_i     (opcode_e'(funct3_i)),
        .bus_gnt_i    (bus_gnt_i),
        .pim_status_i (pim_rdata_i),
        .last_i       (last),
        .phase_o      (phase),
        .cmd_load_o   (cmd_load),
        .cnt_load_o   (cnt_load),
        .cnt_step_o   (cnt_step),
        .addr_step_o  (addr_step),
        .busy_o       (dma_busy_o),
        .bus_req_o    (bus_req_o)
    );

    dma_word_counter u_counter (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .load_i   (cnt_load),
        .step_i   (cnt_step),
        .opcode_i (cmd.opcode),
        .index_o  (index),
        .last_o   (last)
    );

    dma_operand_regs u_operands (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_i      (cmd_load),
        .funct3_i    (opcode_e'(funct3_i)),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .addr_step_i (addr_step),
        .cmd_o       (cmd),
        .sram_addr_o (sram_addr)
    );

    dma_bus_mux u_mux (
        .phase_i      (phase),
        .bus_gnt_i    (bus_gnt_i),
        .cmd_i        (cmd),
        .sram_addr_i  (sram_addr),
        .index_i      (index),
        .last_i       (last),
        .sram_rdata_i (sram_rdata_i),
        .pim_rdata_i  (pim_rdata_i),
        .sram_bus_o   (sram_bus_o),
        .pim_bus_o    (pim_bus_o)
    );

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/pim_cmd_pkg.sv
source/pim_bus_pkg.sv
source/dma_cmd_fsm.sv
source/dma_word_counter.sv
source/dma_operand_regs.sv
source/dma_bus_mux.sv
source/pim_dma_top.sv
sim/pim_dma_chk.sv
sim/tb_pim_dma.sv
